/* hw/dsp_rom_config.svh */
`ifndef DSP_ROM_CONFIG_SVH
`define DSP_ROM_CONFIG_SVH

// Core word address width, 64K words of program space
`define DSP_ROM_AW 16

// Data word width seen by the core
`define DSP_ROM_DW 16

// Internal ROM word address width, 4K words
// Addresses with all upper bits zero hit the internal ROM
`define DSP_ROM_INT_AW 12

// Programming byte address width
// Bit 0 picks the lane, 1 for MSB and 0 for LSB
`define DSP_ROM_PROG_AW 13

`endif

/* hw/dsp_rom_pkg.sv */
`include "dsp_rom_config.svh"

package dsp_rom_pkg;

    // Word address as issued by the core
    typedef logic [`DSP_ROM_AW-1:0] rom_addr_t;

    // Instruction or coefficient word
    typedef logic [`DSP_ROM_DW-1:0] rom_word_t;

    // Fetch unit state
    // Idle accepts requests, ext wait holds until the bus answers
    typedef enum logic {
        FETCH_IDLE,
        FETCH_EXT_WAIT
    } fetch_state_e;

    // External bus phase
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA
    } arb_state_e;

    // Current owner of the bus, or the last one granted
    typedef enum logic {
        OWNER_PC,
        OWNER_PT
    } arb_owner_e;

endpackage

/* hw/rom_req_if.sv */
`timescale 1ns/1ps

interface rom_req_if;

    import dsp_rom_pkg::*;

    // Held high with a stable addr until gnt_done
    logic      req;
    rom_addr_t addr;

    // One-cycle completion strobe, rdata and err valid with it
    logic      gnt_done;
    rom_word_t rdata;
    logic      err;

    // Fetch unit side
    modport requester (
        output req,
        output addr,
        input  gnt_done,
        input  rdata,
        input  err
    );

    // Bus arbiter side
    modport arbiter (
        input  req,
        input  addr,
        output gnt_done,
        output rdata,
        output err
    );

endinterface

/* hw/rom_byte_bank.sv */
`timescale 1ns/1ps
`include "dsp_rom_config.svh"

module rom_byte_bank (
    input  logic                       clk,
    // Port A, shared by programming and PT reads
    input  logic [`DSP_ROM_INT_AW-1:0] addr_a,
    input  logic                       we_a,
    input  logic [7:0]                 din_a,
    output logic [7:0]                 dout_a,
    // Port B, PC reads only
    input  logic [`DSP_ROM_INT_AW-1:0] addr_b,
    output logic [7:0]                 dout_b
);

    // One byte lane of the 4K-word internal ROM
    logic [7:0] mem [0:(1<<`DSP_ROM_INT_AW)-1];

    // Port A write with registered read
    // A read during a write returns the old byte
    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= din_a;
        end
        dout_a <= mem[addr_a];
    end

    // Port B registered read
    always_ff @(posedge clk) begin
        dout_b <= mem[addr_b];
    end

endmodule

/* hw/internal_rom.sv */
`timescale 1ns/1ps
`include "dsp_rom_config.svh"

module internal_rom (
    input  logic                        clk,
    // PT read, shares bank port A with programming
    input  logic [`DSP_ROM_INT_AW-1:0]  pt_addr,
    output dsp_rom_pkg::rom_word_t      pt_data,
    // PC read on bank port B
    input  logic [`DSP_ROM_INT_AW-1:0]  pc_addr,
    output dsp_rom_pkg::rom_word_t      pc_data,
    // Byte-wide programming port
    input  logic                        prog_we,
    input  logic [`DSP_ROM_PROG_AW-1:0] prog_addr,
    input  logic [7:0]                  prog_data
);

    import dsp_rom_pkg::*;

    logic [`DSP_ROM_INT_AW-1:0] addr_a;
    logic                       we_msb;
    logic                       we_lsb;
    logic [7:0]                 msb_a;
    logic [7:0]                 lsb_a;
    logic [7:0]                 msb_b;
    logic [7:0]                 lsb_b;

    // Programming takes port A away from PT
    assign addr_a = prog_we ? prog_addr[`DSP_ROM_PROG_AW-1:1] : pt_addr;

    // Lane select from byte address bit 0
    assign we_msb = prog_we &&  prog_addr[0];
    assign we_lsb = prog_we && !prog_addr[0];

    // Join lanes into words, high byte first
    assign pt_data = {msb_a, lsb_a};
    assign pc_data = {msb_b, lsb_b};

    rom_byte_bank msb_bank_i (
        .clk    (clk),
        .addr_a (addr_a),
        .we_a   (we_msb),
        .din_a  (prog_data),
        .dout_a (msb_a),
        .addr_b (pc_addr),
        .dout_b (msb_b)
    );

    rom_byte_bank lsb_bank_i (
        .clk    (clk),
        .addr_a (addr_a),
        .we_a   (we_lsb),
        .din_a  (prog_data),
        .dout_a (lsb_a),
        .addr_b (pc_addr),
        .dout_b (lsb_b)
    );

endmodule

/* hw/fetch_port.sv */
`timescale 1ns/1ps
`include "dsp_rom_config.svh"

module fetch_port (
    input  logic                       clk,
    input  logic                       rst_n,
    // Core side
    input  logic                       req,
    input  dsp_rom_pkg::rom_addr_t     addr,
    output logic                       ready,
    output logic                       valid,
    output dsp_rom_pkg::rom_word_t     data,
    output logic                       err,
    // Held off while the shared bank port is busy
    input  logic                       stall,
    // Internal ROM read lane
    output logic [`DSP_ROM_INT_AW-1:0] int_addr,
    input  dsp_rom_pkg::rom_word_t     int_data,
    // External bus request
    rom_req_if.requester               ext
);

    import dsp_rom_pkg::*;

    fetch_state_e state;
    rom_addr_t    ext_addr_q;
    logic         is_int;
    logic         accept;
    logic         ext_done;
    logic         pend_valid;

    // Upper address bits all zero means internal ROM
    assign is_int = (addr[`DSP_ROM_AW-1:`DSP_ROM_INT_AW] == '0);

    // External word arrives this cycle
    assign ext_done = (state == FETCH_EXT_WAIT) && ext.gnt_done;

    // Ready again in the same cycle the external word returns
    assign ready  = ((state == FETCH_IDLE) || ext_done) && !stall;
    assign accept = req && ready;

    // Bank samples the address on the accepting edge
    assign int_addr = addr[`DSP_ROM_INT_AW-1:0];

    // External request stays up for the whole wait
    assign ext.req  = (state == FETCH_EXT_WAIT);
    assign ext.addr = ext_addr_q;

    // Internal and external completions never overlap
    assign valid = pend_valid || ext_done;
    assign data  = ext_done ? ext.rdata : int_data;
    assign err   = ext_done && ext.err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FETCH_IDLE;
            pend_valid <= 1'b0;
        end else begin
            // Registered bank word shows up next cycle
            pend_valid <= accept && is_int;
            if (accept && !is_int) begin
                state <= FETCH_EXT_WAIT;
            end else if (ext_done) begin
                state <= FETCH_IDLE;
            end
        end
    end

    // Miss address, held stable for the arbiter
    always_ff @(posedge clk) begin
        if (accept && !is_int) begin
            ext_addr_q <= addr;
        end
    end

endmodule

/* hw/ext_bus_arbiter.sv */
`timescale 1ns/1ps
`include "dsp_rom_config.svh"

module ext_bus_arbiter (
    input  logic         clk,
    input  logic         rst_n,
    // Fetch unit requests
    rom_req_if.arbiter   pc,
    rom_req_if.arbiter   pt,
    // AXI4-Lite read address channel
    output logic [31:0]  araddr,
    output logic         arvalid,
    input  logic         arready,
    // AXI4-Lite read data channel
    input  logic [31:0]  rdata,
    input  logic [1:0]   rresp,
    input  logic         rvalid,
    output logic         rready
);

    import dsp_rom_pkg::*;

    arb_state_e state;
    arb_owner_e owner;
    logic       grant_pt;
    logic       any_req;
    rom_addr_t  sel_addr;
    logic       data_done;
    logic       resp_err;

    assign any_req = pc.req || pt.req;

    // Round robin when both wait, otherwise whoever asks
    always_comb begin
        if (pc.req && pt.req) begin
            grant_pt = (owner == OWNER_PC);
        end else begin
            grant_pt = pt.req;
        end
    end

    assign sel_addr = grant_pt ? pt.addr : pc.addr;

    // Bus handshakes follow the phase
    assign arvalid   = (state == ARB_ADDR);
    assign rready    = (state == ARB_DATA);
    assign data_done = (state == ARB_DATA) && rvalid;

    // Any non-OKAY response is an error
    assign resp_err = (rresp != 2'b00);

    // Word and status go to both, only the owner sees the strobe
    assign pc.gnt_done = data_done && (owner == OWNER_PC);
    assign pt.gnt_done = data_done && (owner == OWNER_PT);
    assign pc.rdata    = rdata[`DSP_ROM_DW-1:0];
    assign pt.rdata    = rdata[`DSP_ROM_DW-1:0];
    assign pc.err      = resp_err;
    assign pt.err      = resp_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            // Last grant marked PT so PC wins the first tie
            owner <= OWNER_PT;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_req) begin
                        owner <= grant_pt ? OWNER_PT : OWNER_PC;
                        state <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (arready) begin
                        state <= ARB_DATA;
                    end
                end
                ARB_DATA: begin
                    if (rvalid) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // Byte address is the word address shifted left once
    always_ff @(posedge clk) begin
        if ((state == ARB_IDLE) && any_req) begin
            araddr <= {{(31-`DSP_ROM_AW){1'b0}}, sel_addr, 1'b0};
        end
    end

endmodule

/* hw/dsp_rom_top.sv */
`timescale 1ns/1ps
`include "dsp_rom_config.svh"

module dsp_rom_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // PC port, instruction fetch
    input  logic                        pc_req,
    input  dsp_rom_pkg::rom_addr_t      pc_addr,
    output logic                        pc_ready,
    output logic                        pc_valid,
    output dsp_rom_pkg::rom_word_t      pc_data,
    output logic                        pc_err,
    // PT port, coefficient tables
    input  logic                        pt_req,
    input  dsp_rom_pkg::rom_addr_t      pt_addr,
    output logic                        pt_ready,
    output logic                        pt_valid,
    output dsp_rom_pkg::rom_word_t      pt_data,
    output logic                        pt_err,
    // Byte-wide ROM programming
    input  logic                        prog_we,
    input  logic [`DSP_ROM_PROG_AW-1:0] prog_addr,
    input  logic [7:0]                  prog_data,
    // AXI4-Lite read master
    output logic [31:0]                 araddr,
    output logic                        arvalid,
    input  logic                        arready,
    input  logic [31:0]                 rdata,
    input  logic [1:0]                  rresp,
    input  logic                        rvalid,
    output logic                        rready
);

    import dsp_rom_pkg::*;

    logic [`DSP_ROM_INT_AW-1:0] pc_int_addr;
    logic [`DSP_ROM_INT_AW-1:0] pt_int_addr;
    rom_word_t                  pc_int_data;
    rom_word_t                  pt_int_data;

    // One request channel per fetch unit
    rom_req_if pc_ext_if ();
    rom_req_if pt_ext_if ();

    internal_rom internal_rom_i (
        .clk       (clk),
        .pt_addr   (pt_int_addr),
        .pt_data   (pt_int_data),
        .pc_addr   (pc_int_addr),
        .pc_data   (pc_int_data),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

    // PC reads on bank port B, never blocked by programming
    fetch_port pc_port_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (pc_req),
        .addr     (pc_addr),
        .ready    (pc_ready),
        .valid    (pc_valid),
        .data     (pc_data),
        .err      (pc_err),
        .stall    (1'b0),
        .int_addr (pc_int_addr),
        .int_data (pc_int_data),
        .ext      (pc_ext_if.requester)
    );

    // PT shares port A with programming
    fetch_port pt_port_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (pt_req),
        .addr     (pt_addr),
        .ready    (pt_ready),
        .valid    (pt_valid),
        .data     (pt_data),
        .err      (pt_err),
        .stall    (prog_we),
        .int_addr (pt_int_addr),
        .int_data (pt_int_data),
        .ext      (pt_ext_if.requester)
    );

    ext_bus_arbiter ext_bus_arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc_ext_if.arbiter),
        .pt      (pt_ext_if.arbiter),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

/* test/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [15:0] SEED = 16'd53792
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic [15:0] lfsr;
    logic [15:0] lfsr_n3;
    logic [1:0]  phase;
    logic [2:0]  cnt;
    logic [15:0] word_q;

    // Fibonacci LFSR, taps 16 14 13 11, new bit enters at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Three steps give one 0..7 delay
    assign lfsr_n3 = lfsr_step(lfsr_step(lfsr_step(lfsr)));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr    <= SEED;
            phase   <= 2'd0;
            cnt     <= 3'd0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= 2'b00;
            word_q  <= '0;
        end else begin
            arready <= 1'b0;
            case (phase)
                // Wait for an address, then pick the arready delay
                2'd0: begin
                    if (arvalid && !arready) begin
                        cnt   <= lfsr_n3[2:0];
                        lfsr  <= lfsr_n3;
                        phase <= 2'd1;
                    end
                end
                // Address stall, then accept and pick the rvalid delay
                2'd1: begin
                    if (cnt == 3'd0) begin
                        arready <= 1'b1;
                        word_q  <= araddr[16:1];
                        cnt     <= lfsr_n3[2:0];
                        lfsr    <= lfsr_n3;
                        phase   <= 2'd2;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                // Data stall, then answer with the formula word
                2'd2: begin
                    if (cnt == 3'd0) begin
                        rvalid <= 1'b1;
                        rdata  <= {16'h0000, word_q[7:0], word_q[15:8]} ^ 32'h0000_5A3C;
                        rresp  <= (word_q >= 16'hF000) ? 2'b10 : 2'b00;
                        phase  <= 2'd3;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                // Hold the beat until the master takes it
                default: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        phase  <= 2'd0;
                    end
                end
            endcase
        end
    end

endmodule

/* test/dsp_rom_tb.sv */
`timescale 1ns/1ps

module dsp_rom_tb;

    import dsp_rom_pkg::*;

    localparam int FILL_BYTES   = 8192;
    localparam int N_PROG       = 32;
    localparam int N_STREAM     = 32;
    localparam int N_EXT        = 12;
    localparam int N_ERR        = 6;
    localparam int N_DUAL       = 10;
    localparam int N_TRANS      = 3 * N_PROG + 3 * N_STREAM + 2 * N_EXT + N_ERR + 2 * N_DUAL;
    localparam int LIMIT_CYCLES = FILL_BYTES + N_TRANS * 200 + 1000;

    logic        clk;
    logic        rst_n;
    logic        pc_req;
    rom_addr_t   pc_addr;
    logic        pc_ready;
    logic        pc_valid;
    rom_word_t   pc_data;
    logic        pc_err;
    logic        pt_req;
    rom_addr_t   pt_addr;
    logic        pt_ready;
    logic        pt_valid;
    rom_word_t   pt_data;
    logic        pt_err;
    logic        prog_we;
    logic [12:0] prog_addr;
    logic [7:0]  prog_data;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // Byte mirror of the internal ROM, index is the programming byte address
    logic [7:0]  mirror [0:FILL_BYTES-1];
    logic [15:0] lfsr;
    rom_addr_t   prog_words[$];
    rom_addr_t   stream_words[$];
    rom_addr_t   dual_pc[$];
    rom_addr_t   dual_pt[$];
    // Port that won the last external grant, 0 for PC and 1 for PT
    int          last_grant;
    int          grants;

    dsp_rom_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_req    (pc_req),
        .pc_addr   (pc_addr),
        .pc_ready  (pc_ready),
        .pc_valid  (pc_valid),
        .pc_data   (pc_data),
        .pc_err    (pc_err),
        .pt_req    (pt_req),
        .pt_addr   (pt_addr),
        .pt_ready  (pt_ready),
        .pt_valid  (pt_valid),
        .pt_data   (pt_data),
        .pt_err    (pt_err),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    axi_mem_model mem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog sized from the transaction count
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the DUT did not finish the tests in %0d cycles", LIMIT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Word from the byte mirror, MSB lane at odd byte address
    function automatic rom_word_t int_word(input rom_addr_t w);
        int_word = {mirror[{w[11:0], 1'b1}], mirror[{w[11:0], 1'b0}]};
    endfunction

    // External rule: byte-swapped address XOR 0x5A3C
    function automatic rom_word_t ext_word(input rom_addr_t w);
        ext_word = {w[7:0], w[15:8]} ^ 16'h5A3C;
    endfunction

    task automatic drive_req(input int port, input logic r, input rom_addr_t a);
        if (port == 0) begin
            pc_req  <= r;
            pc_addr <= a;
        end else begin
            pt_req  <= r;
            pt_addr <= a;
        end
    endtask

    function automatic logic port_ready(input int port);
        port_ready = (port == 0) ? pc_ready : pt_ready;
    endfunction

    function automatic logic port_valid(input int port);
        port_valid = (port == 0) ? pc_valid : pt_valid;
    endfunction

    function automatic rom_word_t port_data(input int port);
        port_data = (port == 0) ? pc_data : pt_data;
    endfunction

    function automatic logic port_err(input int port);
        port_err = (port == 0) ? pc_err : pt_err;
    endfunction

    task automatic prog_byte(input logic [12:0] a, input logic [7:0] d);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= a;
        prog_data <= d;
        mirror[a] = d;
    endtask

    task automatic prog_end();
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // One read on a port, waits for completion and checks the word
    task automatic read_word(input int port, input rom_addr_t a);
        logic internal;
        internal = (a[15:12] == 4'h0);
        @(posedge clk);
        drive_req(port, 1'b1, a);
        @(negedge clk);
        while (!port_ready(port)) @(negedge clk);
        @(posedge clk);
        drive_req(port, 1'b0, a);
        @(negedge clk);
        if (internal) begin
            // Exactly one cycle after acceptance
            check_value(port == 0 ? "pc_valid" : "pt_valid", port_valid(port), 1);
            check_value(port == 0 ? "pc_data" : "pt_data", port_data(port), int_word(a));
        end else begin
            // Busy until the word returns, ready again with it
            while (!port_valid(port)) begin
                check_value(port == 0 ? "pc_ready" : "pt_ready", port_ready(port), 0);
                @(negedge clk);
            end
            check_value(port == 0 ? "pc_ready" : "pt_ready", port_ready(port), 1);
            check_value(port == 0 ? "pc_data" : "pt_data", port_data(port), ext_word(a));
            check_value("araddr", araddr, {15'b0, a, 1'b0});
            last_grant = port;
        end
        check_value(port == 0 ? "pc_err" : "pt_err", port_err(port),
                    (a >= 16'hF000) ? 1 : 0);
    endtask

    // Both ports keep one miss in flight and reissue on completion
    // Every grant but the last is a tie, so grants must alternate
    task automatic dual_stream();
        int        pc_next;
        int        pt_next;
        int        pc_done;
        int        pt_done;
        int        exp_id;
        logic      pc_acc;
        logic      pt_acc;
        rom_addr_t exp_addr;
        pc_next = 0;
        pt_next = 0;
        pc_done = 0;
        pt_done = 0;
        @(posedge clk);
        drive_req(0, 1'b1, dual_pc[0]);
        drive_req(1, 1'b1, dual_pt[0]);
        while ((pc_done < N_DUAL) || (pt_done < N_DUAL)) begin
            @(negedge clk);
            if (arvalid && arready) begin
                // Tie goes to the port not granted last
                if ((pc_done < N_DUAL) && (pt_done < N_DUAL)) begin
                    exp_id = 1 - last_grant;
                end else begin
                    exp_id = (pc_done < N_DUAL) ? 0 : 1;
                end
                exp_addr = (exp_id == 0) ? dual_pc[pc_done] : dual_pt[pt_done];
                check_value("araddr", araddr, {15'b0, exp_addr, 1'b0});
                last_grant = exp_id;
                grants++;
            end
            if (pc_valid) begin
                check_value("pc_data", pc_data, ext_word(dual_pc[pc_done]));
                check_value("pc_err", pc_err, (dual_pc[pc_done] >= 16'hF000) ? 1 : 0);
                pc_done++;
            end
            if (pt_valid) begin
                check_value("pt_data", pt_data, ext_word(dual_pt[pt_done]));
                check_value("pt_err", pt_err, (dual_pt[pt_done] >= 16'hF000) ? 1 : 0);
                pt_done++;
            end
            pc_acc = pc_req && pc_ready;
            pt_acc = pt_req && pt_ready;
            @(posedge clk);
            // Next address goes up right after acceptance
            if (pc_acc) begin
                pc_next++;
                if (pc_next < N_DUAL) begin
                    drive_req(0, 1'b1, dual_pc[pc_next]);
                end else begin
                    drive_req(0, 1'b0, dual_pc[N_DUAL-1]);
                end
            end
            if (pt_acc) begin
                pt_next++;
                if (pt_next < N_DUAL) begin
                    drive_req(1, 1'b1, dual_pt[pt_next]);
                end else begin
                    drive_req(1, 1'b0, dual_pt[N_DUAL-1]);
                end
            end
        end
    endtask

    initial begin
        logic [15:0] r;
        logic [15:0] d;
        rom_addr_t   w;
        rom_addr_t   errs [0:N_ERR-1];

        rst_n     = 1'b0;
        pc_req    = 1'b0;
        pc_addr   = '0;
        pt_req    = 1'b0;
        pt_addr   = '0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        lfsr      = 16'd53792;
        // Reset priority points to PC, as if PT was granted last
        last_grant = 1;
        grants     = 0;
        errs[0] = 16'hF000;
        errs[1] = 16'hFFFF;
        errs[2] = 16'hEFFF;
        errs[3] = 16'h1000;
        errs[4] = 16'hF7A5;
        errs[5] = 16'h8001;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("pc_valid", pc_valid, 0);
        check_value("pt_valid", pt_valid, 0);
        check_value("arvalid", arvalid, 0);
        check_value("rready", rready, 0);
        check_value("pc_ready", pc_ready, 1);
        check_value("pt_ready", pt_ready, 1);

        // Known contents everywhere, pattern uses every address bit
        for (int i = 0; i < FILL_BYTES; i++) begin
            prog_byte(i[12:0], i[7:0] ^ {i[12:8], i[12:10]});
        end
        prog_end();

        // Random bytes, then read the touched words on both ports
        for (int i = 0; i < N_PROG; i++) begin
            take_bits(13, r);
            take_bits(8, d);
            prog_byte(r[12:0], d[7:0]);
            prog_words.push_back({4'h0, r[12:1]});
        end
        prog_end();
        foreach (prog_words[i]) begin
            read_word(0, prog_words[i]);
            read_word(1, prog_words[i]);
        end

        // PC streams from the low half while the high half is programmed
        for (int i = 0; i < N_STREAM; i++) begin
            take_bits(11, r);
            stream_words.push_back({5'b0, r[10:0]});
        end
        for (int i = 0; i <= N_STREAM; i++) begin
            @(posedge clk);
            if (i < N_STREAM) begin
                pc_req  <= 1'b1;
                pc_addr <= stream_words[i];
                take_bits(12, r);
                take_bits(8, d);
                prog_we   <= 1'b1;
                prog_addr <= {1'b1, r[11:0]};
                prog_data <= d[7:0];
                mirror[{1'b1, r[11:0]}] = d[7:0];
            end else begin
                pc_req  <= 1'b0;
                prog_we <= 1'b0;
            end
            @(negedge clk);
            if (i < N_STREAM) begin
                check_value("pc_ready", pc_ready, 1);
                check_value("pt_ready", pt_ready, 0);
            end
            if (i > 0) begin
                check_value("pc_valid", pc_valid, 1);
                check_value("pc_data", pc_data, int_word(stream_words[i-1]));
            end
        end
        @(negedge clk);
        check_value("pt_ready", pt_ready, 1);
        check_value("pc_valid", pc_valid, 0);
        for (int i = 0; i < N_STREAM; i++) begin
            take_bits(11, r);
            read_word(1, {4'h0, 1'b1, r[10:0]});
        end

        // Random external reads on each port
        for (int i = 0; i < N_EXT; i++) begin
            take_bits(16, r);
            w = (r[15:12] == 4'h0) ? {4'h1, r[11:0]} : r;
            read_word(0, w);
            take_bits(16, r);
            w = (r[15:12] == 4'h0) ? {4'h1, r[11:0]} : r;
            read_word(1, w);
        end

        // Error response boundary
        for (int i = 0; i < N_ERR; i++) begin
            read_word(i % 2, errs[i]);
        end

        // Back-to-back misses on both ports, grants must alternate
        for (int i = 0; i < N_DUAL; i++) begin
            take_bits(16, r);
            w = (r[15:12] == 4'h0) ? {4'h2, r[11:0]} : r;
            dual_pc.push_back(w);
            dual_pt.push_back(w ^ 16'h0800);
        end
        dual_stream();
        check_value("grant count", grants, 2 * N_DUAL);

        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* dsp_rom.f */
+incdir+hw/
hw/dsp_rom_pkg.sv
hw/rom_req_if.sv
hw/rom_byte_bank.sv
hw/internal_rom.sv
hw/fetch_port.sv
hw/ext_bus_arbiter.sv
hw/dsp_rom_top.sv
test/axi_mem_model.sv
test/dsp_rom_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
# A failing check ends the run with $fatal, which gives a non-zero exit status
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal -f dsp_rom.f --top-module dsp_rom_tb -o dsp_rom_sim &&
./obj_dir/dsp_rom_sim || {
    echo "Simulation failed"
    exit 1
}
